// File: Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f secv_exec.f --top-module tb_secv_exec -o tb_secv_exec
	./obj_dir/tb_secv_exec | awk '{ print } /^Simulation finished: PASS$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -Wall -f secv_exec.f --top-module tb_secv_exec

clean:
	rm -rf obj_dir

// File: hdl/alu.sv
// Integer ALU function unit for OP, OP-IMM, LUI and AUIPC, combinational inside exec_unit
module alu
    import secv_pkg::*;
(
    input  funit_in_t  fu_i,
    output funit_out_t fu_o,
    output logic       hit_o
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = fu_i.inst.r_type.opcode;
    assign funct3 = fu_i.inst.r_type.funct3;
    assign funct7 = fu_i.inst.r_type.funct7;

    assign hit_o = (opcode == OPCODE_OP)     ||
                   (opcode == OPCODE_OP_IMM) ||
                   (opcode == OPCODE_LUI)    ||
                   (opcode == OPCODE_AUIPC);

    logic            is_op;
    logic            alt;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    assign is_op = opcode == OPCODE_OP;
    assign alt   = funct7 == FUNCT7_ALT;
    assign op_a  = fu_i.rs1_dat;
    // Register operand for OP, immediate for OP-IMM
    assign op_b  = is_op ? fu_i.rs2_dat : fu_i.imm;
    assign shamt = op_b[4:0];

    logic [XLEN-1:0] result;

    always_comb begin
        case (funct3)
            FUNCT3_ALU_ADD: begin
                // SUB exists only in register form
                if (is_op && alt)
                    result = op_a - op_b;
                else
                    result = op_a + op_b;
            end
            FUNCT3_ALU_SLL:  result = op_a << shamt;
            FUNCT3_ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            FUNCT3_ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            FUNCT3_ALU_XOR:  result = op_a ^ op_b;
            FUNCT3_ALU_SR: begin
                // Arithmetic vs logical right shift
                if (alt)
                    result = $signed(op_a) >>> shamt;
                else
                    result = op_a >> shamt;
            end
            FUNCT3_ALU_OR:   result = op_a | op_b;
            default:         result = op_a & op_b;
        endcase
    end

    // funct7 check, U-type opcodes carry immediate bits there
    logic legal;

    always_comb begin
        legal = 1'b1;
        if (is_op || opcode == OPCODE_OP_IMM) begin
            if (alt)
                legal = (funct3 == FUNCT3_ALU_SR) || (is_op && funct3 == FUNCT3_ALU_ADD);
            else if (funct7 != FUNCT7_BASE)
                legal = 1'b0;
        end
    end

    always_comb begin
        fu_o = funit_out_default();
        if (hit_o) begin
            fu_o.err       = ~legal;
            fu_o.rd_dat_wb = legal;
            if (opcode == OPCODE_LUI)
                fu_o.rd_dat = fu_i.imm;
            else if (opcode == OPCODE_AUIPC)
                fu_o.rd_dat = fu_i.pc + fu_i.imm;
            else
                fu_o.rd_dat = result;
        end
    end

endmodule

// File: hdl/branch.sv
// Branch and jump function unit, resolves BRANCH, JAL and JALR combinationally inside exec_unit
module branch
    import secv_pkg::*;
(
    input  funit_in_t  fu_i,
    output funit_out_t fu_o,
    output logic       hit_o
);

    // Decoded fields
    opcode_t opcode;
    funct3_t funct3;

    assign opcode = fu_i.inst.r_type.opcode;
    assign funct3 = fu_i.inst.r_type.funct3;

    // Unit owns all control-transfer opcodes
    assign hit_o = (opcode == OPCODE_BRANCH) ||
                   (opcode == OPCODE_JAL)    ||
                   (opcode == OPCODE_JALR);

    logic [XLEN-1:0] target;
    logic [XLEN-1:0] ret_addr;
    logic [XLEN-1:0] base;

    // JALR is register relative, everything else pc relative
    assign base     = (opcode == OPCODE_JALR) ? fu_i.rs1_dat : fu_i.pc;
    assign target   = base + fu_i.imm;
    // Link address for JAL/JALR
    assign ret_addr = fu_i.pc + 32'd4;

    logic take;
    logic link;
    logic err;

    always_comb begin
        take = 1'b0;
        link = 1'b0;
        err  = 1'b0;

        case (opcode)
            OPCODE_BRANCH: begin
                // Six compare conditions, funct3 2 and 3 unused
                case (funct3)
                    FUNCT3_BRANCH_BEQ:  take = fu_i.rs1_dat == fu_i.rs2_dat;
                    FUNCT3_BRANCH_BNE:  take = fu_i.rs1_dat != fu_i.rs2_dat;
                    FUNCT3_BRANCH_BLT:  take = $signed(fu_i.rs1_dat) < $signed(fu_i.rs2_dat);
                    FUNCT3_BRANCH_BGE:  take = $signed(fu_i.rs1_dat) >= $signed(fu_i.rs2_dat);
                    FUNCT3_BRANCH_BLTU: take = fu_i.rs1_dat < fu_i.rs2_dat;
                    FUNCT3_BRANCH_BGEU: take = fu_i.rs1_dat >= fu_i.rs2_dat;
                    default:            err  = 1'b1;
                endcase
            end
            OPCODE_JAL: begin
                take = 1'b1;
                link = 1'b1;
            end
            OPCODE_JALR: begin
                // Only funct3 zero is defined
                if (funct3 == 3'b000) begin
                    take = 1'b1;
                    link = 1'b1;
                end else begin
                    err = 1'b1;
                end
            end
            default: begin
                take = 1'b0;
            end
        endcase
    end

    // Result stays zero when another unit owns the opcode
    always_comb begin
        fu_o = funit_out_default();
        if (hit_o) begin
            fu_o.err       = err;
            fu_o.pc        = target;
            fu_o.pc_wb     = take;
            fu_o.rd_dat    = ret_addr;
            fu_o.rd_dat_wb = link;
        end
    end

endmodule

// File: hdl/exec_unit.sv
// Combinational execute unit, merges the branch and ALU results and flags unclaimed opcodes
module exec_unit
    import secv_pkg::*;
(
    // Upstream handshake
    input  logic       in_valid_i,
    output logic       in_ready_o,
    input  funit_in_t  fu_i,
    // Downstream handshake
    output logic       out_valid_o,
    input  logic       out_ready_i,
    output funit_out_t fu_o
);

    funit_out_t branch_res;
    funit_out_t alu_res;
    logic       branch_hit;
    logic       alu_hit;

    branch u_branch (
        .fu_i  (fu_i),
        .fu_o  (branch_res),
        .hit_o (branch_hit)
    );

    alu u_alu (
        .fu_i  (fu_i),
        .fu_o  (alu_res),
        .hit_o (alu_hit)
    );

    // Idle unit returns zeros, so OR is a mux
    always_comb begin
        fu_o = funit_out_t'(branch_res | alu_res);
        // Unknown opcode, both flags stay low
        if (!branch_hit && !alu_hit)
            fu_o.err = 1'b1;
    end

    // No state here, handshake passes straight through
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

endmodule

// File: hdl/pipe_stage.sv
// One-entry valid/ready register slice, instantiated at the input and output of the execute stage
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // Upstream side
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    // Downstream side
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // Free when empty or draining this cycle
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            // Refill or go empty
            valid_q <= in_valid_i;
        end
    end

    // Payload only loads on a transfer in
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o)
            data_q <= in_data_i;
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

// File: hdl/secv_exec_top.sv
// Execute stage top level, plain-port wrapper around input slice, execute unit and output slice
module secv_exec_top
    import secv_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Request side
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  logic [31:0]     inst_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_dat_i,
    input  logic [XLEN-1:0] rs2_dat_i,
    input  logic [XLEN-1:0] imm_i,
    // Result side
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output logic            out_err_o,
    output logic [XLEN-1:0] out_pc_o,
    output logic            out_pc_wb_o,
    output logic [XLEN-1:0] out_rd_dat_o,
    output logic            out_rd_dat_wb_o
);

    funit_in_t  req;
    funit_in_t  req_q;
    funit_out_t res;
    funit_out_t res_q;
    logic       req_valid;
    logic       req_ready;
    logic       res_valid;
    logic       res_ready;

    // Pack request ports
    assign req.inst.raw = inst_i;
    assign req.pc       = pc_i;
    assign req.rs1_dat  = rs1_dat_i;
    assign req.rs2_dat  = rs2_dat_i;
    assign req.imm      = imm_i;

    pipe_stage #(.payload_t(funit_in_t)) u_in_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (req),
        .out_valid_o (req_valid),
        .out_ready_i (req_ready),
        .out_data_o  (req_q)
    );

    exec_unit u_exec (
        .in_valid_i  (req_valid),
        .in_ready_o  (req_ready),
        .fu_i        (req_q),
        .out_valid_o (res_valid),
        .out_ready_i (res_ready),
        .fu_o        (res)
    );

    pipe_stage #(.payload_t(funit_out_t)) u_out_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (res_valid),
        .in_ready_o  (res_ready),
        .in_data_i   (res),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (res_q)
    );

    // Unpack result fields
    assign out_err_o       = res_q.err;
    assign out_pc_o        = res_q.pc;
    assign out_pc_wb_o     = res_q.pc_wb;
    assign out_rd_dat_o    = res_q.rd_dat;
    assign out_rd_dat_wb_o = res_q.rd_dat_wb;

endmodule

// File: hdl/secv_pkg.sv
// Shared opcodes, instruction layout and function-unit packets, imported by every execute-stage module
package secv_pkg;

    // Data path width
    localparam int XLEN = 32;

    // Major opcode field
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;

    // Minor opcode field
    typedef logic [2:0] funct3_t;

    // Conditional branch compare codes
    localparam funct3_t FUNCT3_BRANCH_BEQ  = 3'b000;
    localparam funct3_t FUNCT3_BRANCH_BNE  = 3'b001;
    localparam funct3_t FUNCT3_BRANCH_BLT  = 3'b100;
    localparam funct3_t FUNCT3_BRANCH_BGE  = 3'b101;
    localparam funct3_t FUNCT3_BRANCH_BLTU = 3'b110;
    localparam funct3_t FUNCT3_BRANCH_BGEU = 3'b111;

    // Integer operation codes, shared by OP and OP-IMM
    localparam funct3_t FUNCT3_ALU_ADD  = 3'b000;
    localparam funct3_t FUNCT3_ALU_SLL  = 3'b001;
    localparam funct3_t FUNCT3_ALU_SLT  = 3'b010;
    localparam funct3_t FUNCT3_ALU_SLTU = 3'b011;
    localparam funct3_t FUNCT3_ALU_XOR  = 3'b100;
    localparam funct3_t FUNCT3_ALU_SR   = 3'b101;
    localparam funct3_t FUNCT3_ALU_OR   = 3'b110;
    localparam funct3_t FUNCT3_ALU_AND  = 3'b111;

    // Upper instruction field
    typedef logic [6:0] funct7_t;

    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    // SUB, SRA and SRAI
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;

    // R-type field layout, MSB first
    typedef struct packed {
        funct7_t    funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_type_t;

    // Instruction word, field view or raw view
    typedef union packed {
        r_type_t     r_type;
        logic [31:0] raw;
    } inst_t;

    // Operand packet into a function unit, 160 bits
    typedef struct packed {
        inst_t           inst;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_dat;
        logic [XLEN-1:0] rs2_dat;
        // Already sign extended by decode
        logic [XLEN-1:0] imm;
    } funit_in_t;

    // Result packet out of a function unit, 67 bits
    typedef struct packed {
        logic            err;
        // Next pc and its write enable
        logic [XLEN-1:0] pc;
        logic            pc_wb;
        // Destination data and its write enable
        logic [XLEN-1:0] rd_dat;
        logic            rd_dat_wb;
    } funit_out_t;

    // Idle result, all fields zero so units can be OR-merged
    function automatic funit_out_t funit_out_default();
        funit_out_t res;
        res = '0;
        return res;
    endfunction

endpackage

// File: secv_exec.f
hdl/secv_pkg.sv
hdl/pipe_stage.sv
hdl/branch.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/secv_exec_top.sv
test/tb_clock_gen.sv
test/secv_exec_properties.sv
test/tb_secv_exec.sv

// File: test/secv_exec_properties.sv
// Handshake and result-flag assertions, bound into every secv_exec_top instance
module secv_exec_properties
    import secv_pkg::*;
(
    input logic            clk_i,
    input logic            rst_n_i,
    input logic            res_valid_i,
    input logic            res_ready_i,
    input logic            res_err_i,
    input logic [XLEN-1:0] res_pc_i,
    input logic            res_pc_wb_i,
    input logic [XLEN-1:0] res_rd_dat_i,
    input logic            res_rd_dat_wb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Output stage empty in reset and on the first edge after it
    reset_empty: assert property (@(posedge clk_i) !rst_n_i |=> !res_valid_i)
        else $error("out_valid_o high right after reset");

    // Stalled result must stay put
    stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i && !res_ready_i |=> res_valid_i &&
        $stable({res_err_i, res_pc_i, res_pc_wb_i, res_rd_dat_i, res_rd_dat_wb_i}))
        else $error("Stalled result dropped or changed");

    // Faulting instruction never writes rd
    err_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i |-> !(res_err_i && res_rd_dat_wb_i))
        else $error("err and rd_dat_wb both set");

endmodule

bind secv_exec_top secv_exec_properties u_props (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .res_valid_i     (out_valid_o),
    .res_ready_i     (out_ready_i),
    .res_err_i       (out_err_o),
    .res_pc_i        (out_pc_o),
    .res_pc_wb_i     (out_pc_wb_o),
    .res_rd_dat_i    (out_rd_dat_o),
    .res_rd_dat_wb_i (out_rd_dat_wb_o)
);

// File: test/tb_clock_gen.sv
// Testbench clock and reset source, 100 ns clock with reset held low for the first 3 cycles
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 50;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release on a rising edge, like the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: test/tb_secv_exec.sv
// Self-checking testbench for secv_exec_top, random RV32I requests checked against a reference model
module tb_secv_exec
    import secv_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQ        = 600;
    // First requests run at full rate for the latency check
    localparam int FULL_RATE_REQS = 200;
    localparam int CYCLES_PER_REQ = 8;
    localparam int CLK_PERIOD     = 100;
    localparam int PIPE_LATENCY   = 2;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_dat;
    logic [XLEN-1:0] rs2_dat;
    logic [XLEN-1:0] imm;
    logic            out_valid;
    logic            out_ready;
    logic            out_err;
    logic [XLEN-1:0] out_pc;
    logic            out_pc_wb;
    logic [XLEN-1:0] out_rd_dat;
    logic            out_rd_dat_wb;

    // Scoreboard, one entry per accepted request
    funit_out_t exp_q[$];
    string      name_q[$];
    int         acc_q[$];
    bit         timed_q[$];

    int acc_cnt      = 0;
    int recv_cnt     = 0;
    int result_errs  = 0;
    int err_errs     = 0;
    int latency_errs = 0;
    int other_errs   = 0;

    logic [31:0] lfsr_state = 32'h8ee01097;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    secv_exec_top u_dut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .in_valid_i      (in_valid),
        .in_ready_o      (in_ready),
        .inst_i          (inst),
        .pc_i            (pc),
        .rs1_dat_i       (rs1_dat),
        .rs2_dat_i       (rs2_dat),
        .imm_i           (imm),
        .out_valid_o     (out_valid),
        .out_ready_i     (out_ready),
        .out_err_o       (out_err),
        .out_pc_o        (out_pc),
        .out_pc_wb_o     (out_pc_wb),
        .out_rd_dat_o    (out_rd_dat),
        .out_rd_dat_wb_o (out_rd_dat_wb)
    );

    // Galois form, right shift
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    // One LFSR step per bit, first bit lands in the MSB of the field
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Sign and magnitude corner operands
    function automatic logic [XLEN-1:0] boundary_value(input logic [1:0] sel);
        case (sel)
            2'd0:    return 32'h0000_0000;
            2'd1:    return 32'h7fff_ffff;
            2'd2:    return 32'h8000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // LOAD, STORE, SYSTEM, MISC-MEM, none owned by this stage
    function automatic opcode_t unknown_opcode(input logic [1:0] sel);
        case (sel)
            2'd0:    return 7'b0000011;
            2'd1:    return 7'b0100011;
            2'd2:    return 7'b1110011;
            default: return 7'b0001111;
        endcase
    endfunction

    // Expected result, straight from the RV32I execute rules
    function automatic funit_out_t ref_exec(input funit_in_t req, output string name);
        funit_out_t      exp;
        opcode_t         op;
        funct3_t         f3;
        funct7_t         f7;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            legal;
        exp = '0;
        op  = req.inst.r_type.opcode;
        f3  = req.inst.r_type.funct3;
        f7  = req.inst.r_type.funct7;
        a   = req.rs1_dat;
        b   = (op == OPCODE_OP) ? req.rs2_dat : req.imm;
        name = $sformatf("opcode %07b funct3 %0d funct7 %02h", op, f3, f7);
        case (op)
            OPCODE_BRANCH, OPCODE_JAL, OPCODE_JALR: begin
                // Target and link address come out even when not used
                exp.pc     = (op == OPCODE_JALR) ? a + req.imm : req.pc + req.imm;
                exp.rd_dat = req.pc + 32'd4;
                if (op == OPCODE_BRANCH) begin
                    case (f3)
                        3'd0:    exp.pc_wb = a == req.rs2_dat;
                        3'd1:    exp.pc_wb = a != req.rs2_dat;
                        3'd4:    exp.pc_wb = $signed(a) < $signed(req.rs2_dat);
                        3'd5:    exp.pc_wb = $signed(a) >= $signed(req.rs2_dat);
                        3'd6:    exp.pc_wb = a < req.rs2_dat;
                        3'd7:    exp.pc_wb = a >= req.rs2_dat;
                        default: exp.err = 1'b1;
                    endcase
                end else if (op == OPCODE_JAL || f3 == 3'd0) begin
                    exp.pc_wb     = 1'b1;
                    exp.rd_dat_wb = 1'b1;
                end else begin
                    exp.err = 1'b1;
                end
            end
            OPCODE_OP, OPCODE_OP_IMM: begin
                case (f3)
                    3'd0: begin
                        if (op == OPCODE_OP && f7 == FUNCT7_ALT)
                            exp.rd_dat = a - b;
                        else
                            exp.rd_dat = a + b;
                    end
                    3'd1: exp.rd_dat = a << b[4:0];
                    3'd2: exp.rd_dat = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                    3'd3: exp.rd_dat = {{(XLEN-1){1'b0}}, a < b};
                    3'd4: exp.rd_dat = a ^ b;
                    3'd5: begin
                        if (f7 == FUNCT7_ALT)
                            exp.rd_dat = $signed(a) >>> b[4:0];
                        else
                            exp.rd_dat = a >> b[4:0];
                    end
                    3'd6: exp.rd_dat = a | b;
                    default: exp.rd_dat = a & b;
                endcase
                // ALT only for SRA/SRAI and register SUB
                legal = (f7 == FUNCT7_BASE) || (f7 == FUNCT7_ALT &&
                        (f3 == 3'd5 || (op == OPCODE_OP && f3 == 3'd0)));
                exp.err       = !legal;
                exp.rd_dat_wb = legal;
            end
            OPCODE_LUI: begin
                exp.rd_dat    = req.imm;
                exp.rd_dat_wb = 1'b1;
            end
            OPCODE_AUIPC: begin
                exp.rd_dat    = req.pc + req.imm;
                exp.rd_dat_wb = 1'b1;
            end
            default: begin
                exp.err = 1'b1;
            end
        endcase
        return exp;
    endfunction

    task automatic check_result(input string name, input funit_out_t exp, input funit_out_t act);
        if (act.pc !== exp.pc) begin
            $display("[ERROR] %s: pc expected %08h, actual %08h", name, exp.pc, act.pc);
            result_errs++;
        end
        if (act.pc_wb !== exp.pc_wb) begin
            $display("[ERROR] %s: pc_wb expected %0b, actual %0b", name, exp.pc_wb, act.pc_wb);
            result_errs++;
        end
        if (act.rd_dat !== exp.rd_dat) begin
            $display("[ERROR] %s: rd_dat expected %08h, actual %08h",
                     name, exp.rd_dat, act.rd_dat);
            result_errs++;
        end
        if (act.rd_dat_wb !== exp.rd_dat_wb) begin
            $display("[ERROR] %s: rd_dat_wb expected %0b, actual %0b",
                     name, exp.rd_dat_wb, act.rd_dat_wb);
            result_errs++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: err expected %0b, actual %0b", name, exp, act);
            err_errs++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s: latency expected %0d, actual %0d", name, exp, act);
            latency_errs++;
        end
    endtask

    // Random instruction of a random class onto the request ports
    task automatic drive_request();
        logic [31:0]     r;
        logic [2:0]      cls;
        funct3_t         f3;
        funct7_t         f7;
        opcode_t         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_v;
        r   = rand_bits(3);
        cls = r[2:0];
        r   = rand_bits(3);
        f3  = r[2:0];
        r   = rand_bits(1);
        f7  = r[0] ? FUNCT7_ALT : FUNCT7_BASE;
        case (cls)
            3'd0: op = OPCODE_BRANCH;
            3'd1: op = OPCODE_JAL;
            3'd2: begin
                op = OPCODE_JALR;
                // Mostly legal, sometimes a stray funct3
                r = rand_bits(2);
                if (r[1:0] != 2'd0)
                    f3 = 3'd0;
            end
            3'd3: op = OPCODE_OP;
            3'd4: op = OPCODE_OP_IMM;
            3'd5: op = OPCODE_LUI;
            3'd6: op = OPCODE_AUIPC;
            default: begin
                r  = rand_bits(2);
                op = unknown_opcode(r[1:0]);
            end
        endcase
        a = rand_bits(32);
        b = rand_bits(32);
        // Equal pairs and sign corners besides plain random
        r = rand_bits(2);
        if (r[1:0] == 2'd0) begin
            b = a;
        end else if (r[1:0] == 2'd1) begin
            r = rand_bits(4);
            a = boundary_value(r[1:0]);
            b = boundary_value(r[3:2]);
        end
        r     = rand_bits(12);
        imm_v = {{20{r[11]}}, r[11:0]};
        if (op == OPCODE_LUI || op == OPCODE_AUIPC) begin
            r     = rand_bits(20);
            imm_v = {r[19:0], 12'h000};
        end
        r = rand_bits(32);
        pc <= {r[31:2], 2'b00};
        r = rand_bits(15);
        inst     <= {f7, r[14:10], r[9:5], f3, r[4:0], op};
        rs1_dat  <= a;
        rs2_dat  <= b;
        imm      <= imm_v;
        in_valid <= 1'b1;
    endtask

    initial begin : stimulus
        logic [31:0] r;
        int          sent;
        int          total;
        sent      = 0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        inst      = '0;
        pc        = '0;
        rs1_dat   = '0;
        rs2_dat   = '0;
        imm       = '0;
        wait (rst_n === 1'b1);
        while (sent < NUM_REQ) begin
            @(posedge clk);
            if (in_valid && in_ready)
                sent++;
            if (sent == NUM_REQ) begin
                in_valid <= 1'b0;
            end else if (!in_valid || in_ready) begin
                // Idle gaps only after the full-rate part
                r = rand_bits(2);
                if (sent >= FULL_RATE_REQS && r[1:0] == 2'd0)
                    in_valid <= 1'b0;
                else
                    drive_request();
            end
            // Back-pressure once the timed results are out
            if (recv_cnt < FULL_RATE_REQS) begin
                out_ready <= 1'b1;
            end else begin
                r = rand_bits(1);
                out_ready <= r[0];
            end
        end
        out_ready <= 1'b1;
        wait (recv_cnt >= NUM_REQ);
        // Extra edges to catch duplicated results
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d accepted requests never produced a result", exp_q.size());
            other_errs++;
        end
        total = result_errs + err_errs + latency_errs + other_errs;
        $display("Errors: result %0d, err flag %0d, latency %0d, other %0d",
                 result_errs, err_errs, latency_errs, other_errs);
        if (total == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Scoreboard, both transfers sampled on the same edge
    initial begin : compare_results
        funit_in_t  req;
        funit_out_t exp;
        funit_out_t act;
        string      name;
        int         cycle;
        int         acc;
        bit         timed;
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle++;
            if (rst_n) begin
                if (in_valid && in_ready) begin
                    req.inst.raw = inst;
                    req.pc       = pc;
                    req.rs1_dat  = rs1_dat;
                    req.rs2_dat  = rs2_dat;
                    req.imm      = imm;
                    exp = ref_exec(req, name);
                    exp_q.push_back(exp);
                    name_q.push_back($sformatf("req %0d, %s", acc_cnt, name));
                    acc_q.push_back(cycle);
                    timed_q.push_back(acc_cnt < FULL_RATE_REQS);
                    acc_cnt <= acc_cnt + 1;
                end
                if (out_valid && out_ready) begin
                    act.err       = out_err;
                    act.pc        = out_pc;
                    act.pc_wb     = out_pc_wb;
                    act.rd_dat    = out_rd_dat;
                    act.rd_dat_wb = out_rd_dat_wb;
                    if (exp_q.size() == 0) begin
                        $display("Result left the DUT at cycle %0d with no request pending",
                                 cycle);
                        other_errs++;
                    end else begin
                        exp   = exp_q.pop_front();
                        name  = name_q.pop_front();
                        acc   = acc_q.pop_front();
                        timed = timed_q.pop_front();
                        check_err(name, exp.err, act.err);
                        check_result(name, exp, act);
                        if (timed)
                            check_latency(name, PIPE_LATENCY, cycle - acc);
                    end
                    recv_cnt <= recv_cnt + 1;
                end
            end
        end
    end

    // Generous bound of several cycles per request
    initial begin : watchdog
        #(NUM_REQ * CYCLES_PER_REQ * CLK_PERIOD);
        $display("Timeout, the pipeline stalled with %0d of %0d results received",
                 recv_cnt, NUM_REQ);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
